// File: src/pin_config.svh
`ifndef PIN_CONFIG_SVH
`define PIN_CONFIG_SVH

// number of pulse channels in the bank.
`define PIN_COUNT 4

// host bus widths.
`define PIN_ADDR_WIDTH 21
`define PIN_DATA_WIDTH 16

// channel i sits at base address i * stride.
`define PIN_STRIDE 8

// register offsets from each channel base.
`define PIN_OFS_DUTY   1
`define PIN_OFS_ANTI   2
`define PIN_OFS_CYCLES 3
`define PIN_OFS_INF    4

`define PIN_ADDR_GLOBAL 0 // global command, bit 0 is run.

`endif

// File: src/pin_pkg.sv
`default_nettype none

`include "pin_config.svh"

package pin_pkg;

  // one word on the host data bus.
  // also the width of every register and counter.
  typedef logic [`PIN_DATA_WIDTH-1:0] pin_word_t;

  typedef logic [`PIN_ADDR_WIDTH-1:0] pin_addr_t; // host bus address.

  // pulse timer states, one-hot.
  typedef enum logic [2:0] {
    timer_idle = 3'b001,
    timer_high = 3'b010,
    timer_low  = 3'b100
  } timer_state_t;

endpackage

`default_nettype wire

// File: src/pulse_timer.sv
`timescale 1ns/1ps
`default_nettype none

// shapes the duty / anti-duty pulse train on a single pin.
module pulse_timer (
  input  logic               clk,
  input  logic               reset,
  input  logic               run,
  input  pin_pkg::pin_word_t duty,
  input  pin_pkg::pin_word_t anti_duty,
  input  pin_pkg::pin_word_t cycles,
  input  logic               run_inf,
  output logic               pin,
  output logic               busy
);
  import pin_pkg::*;

  timer_state_t state;
  timer_state_t next_state;

  pin_word_t cnt_duty;   // clocks left in the high phase.
  pin_word_t cnt_anti;   // clocks left in the low phase.
  pin_word_t cnt_cycles; // pulses left, frozen in run-forever mode.

  logic start_ok;
  logic duty_done;
  logic anti_done;
  logic last_cycle;
  logic enter_high;
  logic enter_low;
  logic run_done; // a finite run has ended, hold idle until run clears.

  // a run needs nonzero phases and either a count or the forever flag.
  assign start_ok = run && (duty != '0) && (anti_duty != '0) &&
                    ((cycles != '0) || run_inf);

  // compare with <= so a length of zero, written mid-run, still ends the phase.
  assign duty_done  = (cnt_duty <= pin_word_t'(1));
  assign anti_done  = (cnt_anti <= pin_word_t'(1));
  assign last_cycle = !run_inf && (cnt_cycles <= pin_word_t'(1));

  assign enter_high = (state != timer_high) && (next_state == timer_high);
  assign enter_low  = (state == timer_high) && (next_state == timer_low);

  assign busy = (state != timer_idle);

  always_comb begin
    next_state = state;
    if (!run) begin
      next_state = timer_idle; // stop right away.
    end else begin
      case (state)
        timer_idle: begin
          if (start_ok && !run_done)
            next_state = timer_high;
        end
        timer_high: begin
          if (duty_done)
            next_state = timer_low;
        end
        timer_low: begin
          if (anti_done)
            next_state = last_cycle ? timer_idle : timer_high;
        end
        default: next_state = timer_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      state <= timer_idle;
    else
      state <= next_state;
  end

  // cleared with run, so each setting of the run bit gives one finite train.
  always_ff @(posedge clk) begin
    if (reset)
      run_done <= 1'b0;
    else if (!run)
      run_done <= 1'b0;
    else if (state == timer_low && next_state == timer_idle)
      run_done <= 1'b1;
  end

  // pin trails the state by one clock.
  // the run term pulls it low on the edge after run clears.
  always_ff @(posedge clk) begin
    if (reset)
      pin <= 1'b0;
    else
      pin <= run && (state == timer_high);
  end

  always_ff @(posedge clk) begin
    if (reset)
      cnt_duty <= '0;
    else if (enter_high)
      cnt_duty <= duty; // new duty value picked up here.
    else if (state == timer_high)
      cnt_duty <= cnt_duty - pin_word_t'(1);
  end

  always_ff @(posedge clk) begin
    if (reset)
      cnt_anti <= '0;
    else if (enter_low)
      cnt_anti <= anti_duty;
    else if (state == timer_low)
      cnt_anti <= cnt_anti - pin_word_t'(1);
  end

  // loaded once at start, counted down at the end of each low phase.
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_cycles <= '0;
    end else if (state == timer_idle && enter_high) begin
      cnt_cycles <= cycles;
    end else if (state == timer_low && enter_high && !run_inf) begin
      cnt_cycles <= cnt_cycles - pin_word_t'(1);
    end
  end

endmodule

`default_nettype wire

// File: src/pin_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "pin_config.svh"

// one channel: four registers at its base plus the pulse timer.
module pin_channel #(
  parameter pin_pkg::pin_addr_t POSITION = '0
) (
  input  logic               clk,
  input  logic               reset,
  input  pin_pkg::pin_addr_t addr,
  input  logic               write,
  input  pin_pkg::pin_word_t data_in,
  input  logic               run,
  output pin_pkg::pin_word_t read_data,
  output logic               pin
);
  import pin_pkg::*;

  // register map of this channel.
  localparam pin_addr_t addr_base   = POSITION;
  localparam pin_addr_t addr_duty   = POSITION + pin_addr_t'(`PIN_OFS_DUTY);
  localparam pin_addr_t addr_anti   = POSITION + pin_addr_t'(`PIN_OFS_ANTI);
  localparam pin_addr_t addr_cycles = POSITION + pin_addr_t'(`PIN_OFS_CYCLES);
  localparam pin_addr_t addr_inf    = POSITION + pin_addr_t'(`PIN_OFS_INF);

  pin_word_t duty;      // high length in clocks.
  pin_word_t anti_duty; // low length in clocks.
  pin_word_t cycles;    // pulses per run.
  pin_word_t run_inf;   // nonzero means repeat until run clears.

  logic busy;
  logic inf_mode;

  assign inf_mode = (run_inf != '0);

  // register writes, only on the write strobe.
  always_ff @(posedge clk) begin
    if (reset) begin
      duty      <= '0;
      anti_duty <= '0;
      cycles    <= '0;
      run_inf   <= '0;
    end else if (write) begin
      case (addr)
        addr_duty:   duty      <= data_in;
        addr_anti:   anti_duty <= data_in;
        addr_cycles: cycles    <= data_in;
        addr_inf:    run_inf   <= data_in;
        default:     ;
      endcase
    end
  end

  // readback is combinational here.
  // the bank registers the merged word.
  always_comb begin
    case (addr)
      addr_base:   read_data = pin_word_t'(busy); // status, bit 0 is busy.
      addr_duty:   read_data = duty;
      addr_anti:   read_data = anti_duty;
      addr_cycles: read_data = cycles;
      addr_inf:    read_data = run_inf;
      default:     read_data = '0;
    endcase
  end

  pulse_timer i_pulse_timer (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .duty      (duty),
    .anti_duty (anti_duty),
    .cycles    (cycles),
    .run_inf   (inf_mode),
    .pin       (pin),
    .busy      (busy)
  );

endmodule

`default_nettype wire

// File: src/pin_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "pin_config.svh"

// top of the pin bank: global command, channel array, registered readback.
module pin_bank (
  input  logic                    clk,
  input  logic                    reset,
  input  pin_pkg::pin_addr_t      addr,
  input  logic                    write,
  input  pin_pkg::pin_word_t      data_in,
  output pin_pkg::pin_word_t      data_out,
  output logic [`PIN_COUNT-1:0]   pins
);
  import pin_pkg::*;

  localparam pin_addr_t addr_global = pin_addr_t'(`PIN_ADDR_GLOBAL);

  pin_word_t global_command; // bit 0 is the shared run bit.
  pin_word_t global_read;
  pin_word_t read_word;
  pin_word_t channel_read [`PIN_COUNT];

  logic run;

  assign run = global_command[0];

  always_ff @(posedge clk) begin
    if (reset)
      global_command <= '0;
    else if (write && addr == addr_global)
      global_command <= data_in;
  end

  assign global_read = (addr == addr_global) ? global_command : '0;

  for (genvar i = 0; i < `PIN_COUNT; i++) begin : g_channel
    pin_channel #(
      .POSITION (pin_addr_t'(i * `PIN_STRIDE))
    ) i_pin_channel (
      .clk       (clk),
      .reset     (reset),
      .addr      (addr),
      .write     (write),
      .data_in   (data_in),
      .run       (run),
      .read_data (channel_read[i]),
      .pin       (pins[i])
    );
  end

  // each source is zero unless addressed, so a plain OR merges them.
  always_comb begin
    read_word = global_read;
    for (int i = 0; i < `PIN_COUNT; i++)
      read_word = read_word | channel_read[i];
  end

  // one cycle of read latency.
  always_ff @(posedge clk) begin
    if (reset)
      data_out <= '0;
    else
      data_out <= read_word;
  end

endmodule

`default_nettype wire

// File: testbench/pin_bank_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "pin_config.svh"

// pulse shape checks, bound into pin_bank.
module pin_bank_assert (
  input logic                  clk,
  input logic                  reset,
  input pin_pkg::pin_addr_t    addr,
  input logic                  write,
  input pin_pkg::pin_word_t    data_in,
  input logic                  run,
  input logic [`PIN_COUNT-1:0] pins
);
  import pin_pkg::*;

  int fail_count = 0;

  // every pin is low on the edge after a reset cycle.
  a_reset_pins: assert property (@(posedge clk) reset |=> (pins == '0))
    else begin $error("pins not low after reset"); fail_count++; end

  for (genvar c = 0; c < `PIN_COUNT; c++) begin : g_chk
    localparam pin_addr_t base = pin_addr_t'(c * `PIN_STRIDE);

    pin_word_t duty_m;
    pin_word_t anti_m;
    pin_word_t cyc_m;
    pin_word_t inf_m;
    pin_word_t high_cnt; // length of the current or last high run.
    pin_word_t low_cnt;
    pin_word_t pulses;   // rising edges since run was set.
    logic      prev;
    logic      seen_fall;

    always_ff @(posedge clk) begin
      if (reset) begin
        duty_m <= '0;
        anti_m <= '0;
        cyc_m  <= '0;
        inf_m  <= '0;
      end else if (write) begin
        if (addr == base + pin_addr_t'(`PIN_OFS_DUTY))   duty_m <= data_in;
        if (addr == base + pin_addr_t'(`PIN_OFS_ANTI))   anti_m <= data_in;
        if (addr == base + pin_addr_t'(`PIN_OFS_CYCLES)) cyc_m  <= data_in;
        if (addr == base + pin_addr_t'(`PIN_OFS_INF))    inf_m  <= data_in;
      end
    end

    always_ff @(posedge clk) begin
      if (reset || !run) begin
        prev      <= 1'b0;
        high_cnt  <= '0;
        low_cnt   <= '0;
        pulses    <= '0;
        seen_fall <= 1'b0;
      end else begin
        prev <= pins[c];
        if (pins[c])
          high_cnt <= prev ? high_cnt + pin_word_t'(1) : pin_word_t'(1);
        else
          low_cnt <= prev ? pin_word_t'(1) : low_cnt + pin_word_t'(1);
        if (pins[c] && !prev)
          pulses <= pulses + pin_word_t'(1);
        if (!pins[c] && prev)
          seen_fall <= 1'b1;
      end
    end

    a_high_len: assert property (@(posedge clk) disable iff (reset)
      (run && prev && !pins[c]) |-> (high_cnt == duty_m))
      else begin $error("high phase length wrong on pin %0d", c); fail_count++; end

    a_low_len: assert property (@(posedge clk) disable iff (reset)
      (run && !prev && pins[c] && seen_fall) |-> (low_cnt == anti_m))
      else begin $error("low phase length wrong on pin %0d", c); fail_count++; end

    // a finished finite run has given exactly cycles pulses.
    a_count: assert property (@(posedge clk) disable iff (reset)
      (run && inf_m == '0 && seen_fall && !pins[c] && low_cnt > anti_m) |->
      (pulses == cyc_m))
      else begin $error("pulse count wrong on pin %0d", c); fail_count++; end

    a_guard: assert property (@(posedge clk) disable iff (reset)
      (!prev && pins[c]) |->
      (duty_m != '0 && anti_m != '0 && (cyc_m != '0 || inf_m != '0)))
      else begin $error("pin %0d started with a zero setting", c); fail_count++; end

    a_stop: assert property (@(posedge clk) disable iff (reset)
      $fell(run) |=> !pins[c])
      else begin $error("pin %0d still high after run cleared", c); fail_count++; end
  end

endmodule

bind pin_bank pin_bank_assert i_pin_bank_assert (
  .clk     (clk),
  .reset   (reset),
  .addr    (addr),
  .write   (write),
  .data_in (data_in),
  .run     (run),
  .pins    (pins)
);

`default_nettype wire

// File: testbench/tb_pin_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "pin_config.svh"

module tb_pin_bank;
  import pin_pkg::*;

  logic                  clk;
  logic                  reset;
  pin_addr_t             addr;
  logic                  write;
  pin_word_t             data_in;
  pin_word_t             data_out;
  logic [`PIN_COUNT-1:0] pins;

  logic [31:0] lfsr_state;
  int          errors;
  int          assert_fails;
  pin_word_t   expect_reg [`PIN_COUNT][5]; // written values, offsets 1 to 4.
  pin_word_t   global_word;

  pin_bank i_pin_bank (
    .clk      (clk),
    .reset    (reset),
    .addr     (addr),
    .write    (write),
    .data_in  (data_in),
    .data_out (data_out),
    .pins     (pins)
  );

  always #10 clk = ~clk;

  // fibonacci lfsr, taps 32 22 2 1.
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic pin_word_t take_bits(input int n);
    pin_word_t v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[14:0], lfsr_step()};
    return v;
  endfunction

  function automatic pin_word_t small_value();
    return take_bits(3) + pin_word_t'(1); // 1 to 8.
  endfunction

  function automatic pin_addr_t reg_addr(input int ch, input int ofs);
    return pin_addr_t'(ch * `PIN_STRIDE + ofs);
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("test failed");
    $finish;
  endtask

  task automatic write_reg(input pin_addr_t a, input pin_word_t d);
    @(posedge clk);
    #2;
    addr    = a;
    data_in = d;
    write   = 1'b1;
  endtask

  task automatic bus_idle();
    @(posedge clk);
    #2;
    write = 1'b0;
  endtask

  task automatic read_reg(input pin_addr_t a, output pin_word_t v);
    @(posedge clk);
    #2;
    addr  = a;
    write = 1'b0;
    @(posedge clk); // data_out takes the word here.
    @(negedge clk);
    v = data_out;
  endtask

  task automatic check_read(input pin_addr_t a, input pin_word_t expected);
    pin_word_t got;
    read_reg(a, got);
    if (got !== expected) begin
      errors++;
      $display("Mismatch data_out at addr %h: got %h, expected %h", a, got, expected);
    end
  endtask

  task automatic check_pins(input logic [`PIN_COUNT-1:0] expected);
    if (pins !== expected) begin
      errors++;
      $display("Mismatch pins: got %h, expected %h", pins, expected);
    end
  endtask

  task automatic program_channel(input int ch, input pin_word_t d, input pin_word_t a,
                                 input pin_word_t c, input pin_word_t inf);
    write_reg(reg_addr(ch, `PIN_OFS_DUTY), d);
    write_reg(reg_addr(ch, `PIN_OFS_ANTI), a);
    write_reg(reg_addr(ch, `PIN_OFS_CYCLES), c);
    write_reg(reg_addr(ch, `PIN_OFS_INF), inf);
    bus_idle();
  endtask

  task automatic set_run(input logic r);
    write_reg(pin_addr_t'(`PIN_ADDR_GLOBAL), {15'b0, r});
    bus_idle();
  endtask

  task automatic wait_pins_high(input logic [`PIN_COUNT-1:0] mask);
    int n;
    for (n = 0; n < 50; n++) begin
      @(negedge clk);
      if ((pins & mask) == mask)
        break;
    end
    if (n == 50)
      abort_on_timeout("pins to rise");
  endtask

  // returns on the first negedge that sees the pin high after a low one.
  task automatic wait_pin_rise(input int ch);
    int   n;
    logic was_high;
    was_high = pins[ch];
    for (n = 0; n < 50; n++) begin
      @(negedge clk);
      if (pins[ch] && !was_high)
        break;
      was_high = pins[ch];
    end
    if (n == 50)
      abort_on_timeout("a rising pin");
  endtask

  // channel 0 status shares address 0 with the run bit, so it is not polled here.
  task automatic wait_busy_clear(input int ch);
    pin_word_t v;
    int        n;
    for (n = 0; n < 300; n++) begin
      read_reg(reg_addr(ch, 0), v);
      if (v[0] == 1'b0)
        break;
    end
    if (n == 300)
      abort_on_timeout("busy to clear");
  endtask

  // longer than any low phase, so the train has ended.
  task automatic wait_pin_quiet(input int ch);
    int n;
    int quiet;
    quiet = 0;
    for (n = 0; n < 600; n++) begin
      @(negedge clk);
      quiet = pins[ch] ? 0 : quiet + 1;
      if (quiet >= 10)
        break;
    end
    if (n == 600)
      abort_on_timeout("pin 0 to go quiet");
  endtask

  initial begin
    pin_word_t d;
    pin_word_t a;
    int        rises;
    int        span;
    logic      last_pin;

    clk        = 1'b0;
    reset      = 1'b1;
    addr       = '0;
    write      = 1'b0;
    data_in    = '0;
    errors     = 0;
    lfsr_state = 32'h16bfd0f6;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;

    // after reset.
    @(negedge clk);
    check_pins('0);
    check_read(pin_addr_t'(`PIN_ADDR_GLOBAL), '0);
    for (int ch = 0; ch < `PIN_COUNT; ch++)
      for (int ofs = 0; ofs <= 4; ofs++)
        check_read(reg_addr(ch, ofs), '0);

    // register readback with random words.
    for (int ch = 0; ch < `PIN_COUNT; ch++) begin
      for (int ofs = 1; ofs <= 4; ofs++) begin
        expect_reg[ch][ofs] = take_bits(16);
        write_reg(reg_addr(ch, ofs), expect_reg[ch][ofs]);
      end
    end
    global_word = take_bits(16) & 16'hfffe; // keep run clear.
    write_reg(pin_addr_t'(`PIN_ADDR_GLOBAL), global_word);
    bus_idle();
    check_read(pin_addr_t'(`PIN_ADDR_GLOBAL), global_word);
    for (int ch = 0; ch < `PIN_COUNT; ch++)
      for (int ofs = 1; ofs <= 4; ofs++)
        check_read(reg_addr(ch, ofs), expect_reg[ch][ofs]);
    check_read(reg_addr(1, 5), '0);
    check_read(reg_addr(3, 7), '0);
    check_read(pin_addr_t'(21'h1fffff), '0);

    // finite pulse trains on all channels.
    for (int ch = 0; ch < `PIN_COUNT; ch++)
      program_channel(ch, small_value(), small_value(), small_value(), '0);
    set_run(1'b1);
    wait_pins_high('1);
    for (int ch = 1; ch < `PIN_COUNT; ch++)
      wait_busy_clear(ch);
    wait_pin_quiet(0);
    @(negedge clk);
    check_pins('0);
    set_run(1'b0);

    // start guard, one zero setting on each of channels 1 to 3.
    program_channel(0, small_value(), small_value(), small_value(), '0);
    program_channel(1, '0, small_value(), small_value(), '0);
    program_channel(2, small_value(), '0, small_value(), '0);
    program_channel(3, small_value(), small_value(), '0, '0);
    set_run(1'b1);
    repeat (40) begin
      @(negedge clk);
      if (pins[3:1] !== 3'b000) begin
        errors++;
        $display("Mismatch pins[3:1]: got %h, expected %h", pins[3:1], 3'h0);
      end
    end
    set_run(1'b0);

    // run forever on channel 2 with a cycle count of one.
    d = small_value();
    a = small_value();
    for (int ch = 0; ch < `PIN_COUNT; ch++)
      program_channel(ch, '0, '0, '0, '0);
    program_channel(2, d, a, pin_word_t'(1), pin_word_t'(1));
    set_run(1'b1);
    wait_pins_high(4'b0100);
    span = int'(d) + int'(a);
    repeat (span + 2) @(negedge clk);
    rises    = 0;
    last_pin = pins[2];
    repeat (2 * span + 2) begin
      @(negedge clk);
      if (pins[2] && !last_pin)
        rises++;
      last_pin = pins[2];
    end
    if (rises == 0) begin
      errors++;
      $display("channel 2 stopped toggling in run-forever mode");
    end
    check_read(reg_addr(2, 0), pin_word_t'(1));
    // run clears on the edge where the pin would rise two periods on.
    wait_pin_rise(2);
    repeat (2 * span - 3) @(posedge clk);
    set_run(1'b0);
    @(posedge clk);
    @(negedge clk);
    check_pins('0);
    repeat (4) @(posedge clk);

    assert_fails = i_pin_bank.i_pin_bank_assert.fail_count;
    $display("errors: readback %0d, assertions %0d", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+src
src/pin_pkg.sv
src/pulse_timer.sv
src/pin_channel.sv
src/pin_bank.sv
testbench/pin_bank_assert.sv
testbench/tb_pin_bank.sv

// File: run_pin_bank.sh
#!/bin/sh
# build and run the pin bank testbench with verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_pin_bank -o sim_pin_bank

# keep running after an assertion error so the testbench prints its summary.
./obj_dir/sim_pin_bank +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "test passed" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
